//--- soc_defines.svh
//////////////////////////////////////////////////
// soc-wide sizes for ram, output fifo and reset hold
//////////////////////////////////////////////////

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// byte address bits of the shared ram, 128 KiB
`define SOC_RAM_ADDR_W 17

// entries in the cpu output fifo
`define SOC_IO_FIFO_DEPTH 4

// cycles a reset stays high after its cause ends
`define SOC_RST_HOLD 2

`endif

//--- soc_pkg.sv
//////////////////////////////////////////////////
// soc types: widths, host enums and bus structs
//////////////////////////////////////////////////

`include "soc_defines.svh"

package soc_pkg;

  typedef logic [31:0]                  addr_t;
  typedef logic [`SOC_RAM_ADDR_W-1:0]   ram_addr_t;
  typedef logic [7:0]                   byte_t;
  // io register select, low cpu address bits
  typedef logic [2:0]                   io_sel_t;

  typedef enum logic [1:0] {
    HOST_START,
    HOST_WRITE,
    HOST_READ,
    HOST_FINISH
  } host_op_t;

  typedef enum logic {
    H_IDLE,
    H_ACTIVE
  } host_state_t;

  typedef struct packed {
    addr_t addr;
    byte_t wdata;
    logic  wr;
  } cpu_req_t;

  typedef struct packed {
    logic      valid;
    host_op_t  op;
    ram_addr_t addr;
    byte_t     data;
  } host_cmd_t;

  typedef struct packed {
    ram_addr_t addr;
    byte_t     wdata;
    logic      we;
  } ram_req_t;

  typedef struct packed {
    logic    en;
    io_sel_t sel;
    byte_t   wdata;
    logic    wr;
  } io_req_t;

  typedef struct packed {
    logic  valid;
    byte_t data;
  } tx_byte_t;

endpackage

//--- sys_reset.sv
//////////////////////////////////////////////////
// button reset sync and cpu reset stretcher
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_defines.svh"

module sys_reset (
  input  logic clk,
  input  logic btnC,
  input  logic finish,
  output logic rst,
  output logic cpu_rst
);

  localparam int HOLD = `SOC_RST_HOLD;

  logic [HOLD-1:0] sys_chain;
  logic [HOLD-1:0] fin_chain;

  // async assert, release after HOLD edges
  always_ff @(posedge clk or posedge btnC) begin
    if (btnC) begin
      sys_chain <= '1;
    end else begin
      sys_chain <= sys_chain << 1;
    end
  end

  // finish reloads the chain, giving a timed cpu reset
  always_ff @(posedge clk or posedge btnC) begin
    if (btnC) begin
      fin_chain <= '0;
    end else if (finish) begin
      fin_chain <= '1;
    end else begin
      fin_chain <= fin_chain << 1;
    end
  end

  assign rst     = sys_chain[HOLD-1];
  assign cpu_rst = rst | fin_chain[HOLD-1];

endmodule

//--- byte_ram.sv
//////////////////////////////////////////////////
// single-port byte ram, registered read
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_defines.svh"

module byte_ram (
  input  logic              clk,
  input  soc_pkg::ram_req_t req,
  output soc_pkg::byte_t    rdata
);

  localparam int WORDS = 2 ** `SOC_RAM_ADDR_W;

  soc_pkg::byte_t mem [WORDS];

  // read every cycle, old data on a write to the same address
  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
    rdata <= mem[req.addr];
  end

endmodule

//--- host_link.sv
//////////////////////////////////////////////////
// host command decode, active fsm, ram access
//////////////////////////////////////////////////

`timescale 1ns/1ps

module host_link (
  input  logic               clk,
  input  logic               rst,
  input  soc_pkg::host_cmd_t cmd,
  input  soc_pkg::byte_t     ram_rdata,
  output logic               active,
  output soc_pkg::ram_req_t  ram_req,
  output soc_pkg::tx_byte_t  rdata,
  output logic               finish
);

  soc_pkg::host_state_t state;
  soc_pkg::host_state_t state_next;
  logic                 is_active;
  logic                 do_start;
  logic                 do_write;
  logic                 do_read;
  logic                 do_finish;
  logic                 rd_pending;

  assign is_active = (state == soc_pkg::H_ACTIVE);

  // each strobe is one command
  assign do_start  = cmd.valid & ~is_active & (cmd.op == soc_pkg::HOST_START);
  assign do_write  = cmd.valid & is_active & (cmd.op == soc_pkg::HOST_WRITE);
  assign do_read   = cmd.valid & is_active & (cmd.op == soc_pkg::HOST_READ);
  assign do_finish = cmd.valid & is_active & (cmd.op == soc_pkg::HOST_FINISH);

  always_comb begin
    state_next = state;
    case (state)
      soc_pkg::H_IDLE: begin
        if (do_start) begin
          state_next = soc_pkg::H_ACTIVE;
        end
      end
      soc_pkg::H_ACTIVE: begin
        if (do_finish) begin
          state_next = soc_pkg::H_IDLE;
        end
      end
      default: state_next = soc_pkg::H_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= soc_pkg::H_IDLE;
      rd_pending <= 1'b0;
      finish     <= 1'b0;
    end else begin
      state      <= state_next;
      rd_pending <= do_read;
      finish     <= do_finish;
    end
  end

  assign active  = is_active;
  assign ram_req = '{addr: cmd.addr, wdata: cmd.data, we: do_write};

  // ram data lands one edge after the read strobe
  assign rdata = '{valid: rd_pending, data: ram_rdata};

endmodule

//--- mem_bus_mux.sv
//////////////////////////////////////////////////
// ram owner mux, io window decode, cpu read path
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_defines.svh"

module mem_bus_mux (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::cpu_req_t cpu_req,
  input  logic              host_active,
  input  soc_pkg::ram_req_t host_ram_req,
  input  soc_pkg::byte_t    ram_rdata,
  input  soc_pkg::byte_t    io_rdata,
  output soc_pkg::ram_req_t ram_req,
  output soc_pkg::io_req_t  io_req,
  output soc_pkg::byte_t    cpu_rdata,
  output logic              cpu_rdy
);

  localparam int AW = `SOC_RAM_ADDR_W;

  logic io_hit;
  logic rd_from_io;

  // io window at the top of the address map, bits AW:AW-1 both set
  assign io_hit = (cpu_req.addr[AW:AW-1] == 2'b11);

  // cpu waits while the host owns the ram
  assign cpu_rdy = ~host_active;

  always_comb begin
    if (host_active) begin
      ram_req = host_ram_req;
    end else begin
      ram_req.addr  = cpu_req.addr[AW-1:0];
      ram_req.wdata = cpu_req.wdata;
      // io writes stay off the ram
      ram_req.we    = cpu_req.wr & ~io_hit;
    end
  end

  assign io_req = '{
    en:    io_hit & cpu_rdy,
    sel:   cpu_req.addr[2:0],
    wdata: cpu_req.wdata,
    wr:    cpu_req.wr
  };

  // remembers where the pending read comes from
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_from_io <= 1'b0;
    end else if (cpu_rdy) begin
      rd_from_io <= io_hit;
    end
  end

  assign cpu_rdata = rd_from_io ? io_rdata : ram_rdata;

endmodule

//--- io_port.sv
//////////////////////////////////////////////////
// cpu output fifo, status read and tx drain
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_defines.svh"

module io_port (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::io_req_t  req,
  input  logic              tx_take,
  output soc_pkg::byte_t    rdata,
  output logic              full,
  output soc_pkg::tx_byte_t tx_out
);

  localparam int DEPTH = `SOC_IO_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  soc_pkg::byte_t   fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             empty;
  logic             push;
  logic             pop;
  logic             tx_valid;
  soc_pkg::byte_t   tx_data;
  soc_pkg::byte_t   status;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  // select 0 is the data port, writes into a full fifo are lost
  assign push  = req.en & req.wr & (req.sel == soc_pkg::io_sel_t'(0)) & ~full;
  assign pop   = tx_take & ~empty;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      full     <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count    <= count_next;
      full     <= (count_next == CNT_W'(DEPTH));
      tx_valid <= pop;
    end
  end

  // status byte: bit 0 full, bit 1 empty
  assign status = (req.sel == soc_pkg::io_sel_t'(4)) ? {6'b0, empty, full} : 8'h00;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= req.wdata;
    end
    if (pop) begin
      tx_data <= fifo_mem[rd_ptr];
    end
    rdata <= status;
  end

  assign tx_out = '{valid: tx_valid, data: tx_data};

endmodule

//--- soc_top.sv
//////////////////////////////////////////////////
// soc memory and io fabric top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_top (
  input  logic               clk,
  input  logic               btnC,
  input  soc_pkg::cpu_req_t  cpu_req,
  output soc_pkg::byte_t     cpu_rdata,
  output logic               cpu_rdy,
  output logic               cpu_io_full,
  output logic               cpu_rst,
  input  soc_pkg::host_cmd_t host_cmd,
  output soc_pkg::tx_byte_t  host_rdata,
  input  logic               tx_take,
  output soc_pkg::tx_byte_t  tx_out
);

  logic              rst;
  logic              finish;
  logic              host_active;
  soc_pkg::ram_req_t host_ram_req;
  soc_pkg::ram_req_t ram_req;
  soc_pkg::byte_t    ram_rdata;
  soc_pkg::io_req_t  io_req;
  soc_pkg::byte_t    io_rdata;

  sys_reset u_sys_reset (
    .clk     (clk),
    .btnC    (btnC),
    .finish  (finish),
    .rst     (rst),
    .cpu_rst (cpu_rst)
  );

  // shared between host loader and cpu
  byte_ram u_byte_ram (
    .clk   (clk),
    .req   (ram_req),
    .rdata (ram_rdata)
  );

  host_link u_host_link (
    .clk       (clk),
    .rst       (rst),
    .cmd       (host_cmd),
    .ram_rdata (ram_rdata),
    .active    (host_active),
    .ram_req   (host_ram_req),
    .rdata     (host_rdata),
    .finish    (finish)
  );

  mem_bus_mux u_mem_bus_mux (
    .clk          (clk),
    .rst          (rst),
    .cpu_req      (cpu_req),
    .host_active  (host_active),
    .host_ram_req (host_ram_req),
    .ram_rdata    (ram_rdata),
    .io_rdata     (io_rdata),
    .ram_req      (ram_req),
    .io_req       (io_req),
    .cpu_rdata    (cpu_rdata),
    .cpu_rdy      (cpu_rdy)
  );

  io_port u_io_port (
    .clk     (clk),
    .rst     (rst),
    .req     (io_req),
    .tx_take (tx_take),
    .rdata   (io_rdata),
    .full    (cpu_io_full),
    .tx_out  (tx_out)
  );

endmodule

//--- tb_soc_top.sv
//////////////////////////////////////////////////
// testbench: trace replay, typed checks, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_soc_top;

  logic               clk;
  logic               btnC;
  logic               tx_take;
  soc_pkg::cpu_req_t  cpu_req;
  soc_pkg::host_cmd_t host_cmd;
  soc_pkg::byte_t     cpu_rdata;
  logic               cpu_rdy;
  logic               cpu_io_full;
  logic               cpu_rst;
  soc_pkg::tx_byte_t  host_rdata;
  soc_pkg::tx_byte_t  tx_out;

  logic [7:0]     op_q [$];
  logic [31:0]    addr_q [$];
  logic [31:0]    data_q [$];
  int             line_q [$];
  // expected bytes of the random scratch region
  soc_pkg::byte_t scratch_exp [16];
  integer         seed;
  logic           trace_loaded;
  int             byte_errs;
  int             flag_errs;
  int             tx_errs;
  int             other_errs;

  soc_top uut (
    .clk         (clk),
    .btnC        (btnC),
    .cpu_req     (cpu_req),
    .cpu_rdata   (cpu_rdata),
    .cpu_rdy     (cpu_rdy),
    .cpu_io_full (cpu_io_full),
    .cpu_rst     (cpu_rst),
    .host_cmd    (host_cmd),
    .host_rdata  (host_rdata),
    .tx_take     (tx_take),
    .tx_out      (tx_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_byte(input string name, input soc_pkg::byte_t exp,
                            input soc_pkg::byte_t act);
    if (act !== exp) begin
      byte_errs++;
      $display("[FAIL] %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("[FAIL] %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  task automatic check_tx(input string name, input soc_pkg::tx_byte_t exp,
                          input soc_pkg::tx_byte_t act);
    if (act !== exp) begin
      tx_errs++;
      $display("[FAIL] %s expected valid %0b data %02h actual valid %0b data %02h",
               name, exp.valid, exp.data, act.valid, act.data);
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    int          ln;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    ln = 0;
    fd = $fopen("soc_trace.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the trace file soc_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        ln++;
        // lines starting with # describe the columns
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h", op, a, d);
          if (n == 3) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            line_q.push_back(ln);
          end else begin
            other_errs++;
            $display("trace line %0d could not be parsed", ln);
          end
        end
      end
      $fclose(fd);
    end
    trace_loaded = 1'b1;
  endtask

  task automatic present_host_cmd(input soc_pkg::host_op_t op, input soc_pkg::ram_addr_t a,
                                  input soc_pkg::byte_t d);
    @(posedge clk);
    host_cmd <= '{valid: 1'b1, op: op, addr: a, data: d};
  endtask

  task automatic clear_host_cmd();
    @(posedge clk);
    host_cmd.valid <= 1'b0;
  endtask

  task automatic read_host_byte(input string name, input soc_pkg::ram_addr_t a,
                                input soc_pkg::byte_t exp);
    soc_pkg::tx_byte_t want;
    want.valid = 1'b1;
    want.data  = exp;
    present_host_cmd(soc_pkg::HOST_READ, a, 8'h00);
    @(negedge clk);
    check_flag({name, " early valid"}, 1'b0, host_rdata.valid);
    clear_host_cmd();
    @(negedge clk);
    check_tx(name, want, host_rdata);
  endtask

  task automatic start_host(input string name);
    present_host_cmd(soc_pkg::HOST_START, '0, 8'h00);
    @(negedge clk);
    check_flag({name, " rdy before"}, 1'b1, cpu_rdy);
    clear_host_cmd();
    @(negedge clk);
    check_flag({name, " rdy low"}, 1'b0, cpu_rdy);
  endtask

  // rdy rises one cycle after the strobe, cpu_rst follows for two cycles
  task automatic finish_host(input string name);
    present_host_cmd(soc_pkg::HOST_FINISH, '0, 8'h00);
    @(negedge clk);
    check_flag({name, " rdy before"}, 1'b0, cpu_rdy);
    clear_host_cmd();
    @(negedge clk);
    check_flag({name, " rdy high"}, 1'b1, cpu_rdy);
    check_flag({name, " cpu_rst before"}, 1'b0, cpu_rst);
    @(negedge clk);
    check_flag({name, " cpu_rst 1"}, 1'b1, cpu_rst);
    @(negedge clk);
    check_flag({name, " cpu_rst 2"}, 1'b1, cpu_rst);
    @(negedge clk);
    check_flag({name, " cpu_rst end"}, 1'b0, cpu_rst);
  endtask

  task automatic fill_scratch(input logic [31:0] base, input logic [31:0] count);
    logic [31:0] rnd;
    for (int i = 0; i < 16 && i < count; i++) begin
      rnd = $random(seed);
      scratch_exp[i] = rnd[7:0];
      present_host_cmd(soc_pkg::HOST_WRITE, soc_pkg::ram_addr_t'(base + i), rnd[7:0]);
      clear_host_cmd();
    end
  endtask

  task automatic verify_scratch(input string name, input logic [31:0] base,
                                input logic [31:0] count);
    for (int i = 0; i < 16 && i < count; i++) begin
      read_host_byte($sformatf("%s byte %0d", name, i),
                     soc_pkg::ram_addr_t'(base + i), scratch_exp[i]);
    end
  endtask

  task automatic drive_cpu_write(input logic [31:0] a, input soc_pkg::byte_t d);
    @(posedge clk);
    cpu_req <= '{addr: a, wdata: d, wr: 1'b1};
    @(posedge clk);
    cpu_req.wr <= 1'b0;
  endtask

  task automatic read_cpu_byte(input string name, input logic [31:0] a,
                               input soc_pkg::byte_t exp);
    @(posedge clk);
    cpu_req <= '{addr: a, wdata: 8'h00, wr: 1'b0};
    @(posedge clk);
    @(negedge clk);
    check_byte(name, exp, cpu_rdata);
  endtask

  task automatic take_tx_byte(input string name, input soc_pkg::byte_t exp);
    soc_pkg::tx_byte_t want;
    want.valid = 1'b1;
    want.data  = exp;
    @(posedge clk);
    tx_take <= 1'b1;
    @(negedge clk);
    check_flag({name, " early valid"}, 1'b0, tx_out.valid);
    @(posedge clk);
    tx_take <= 1'b0;
    @(negedge clk);
    check_tx(name, want, tx_out);
  endtask

  task automatic run_line(input int idx);
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    string       name;
    op   = op_q[idx];
    a    = addr_q[idx];
    d    = data_q[idx];
    name = $sformatf("line %0d %c", line_q[idx], op);
    case (op)
      "S": start_host(name);
      "W": begin
        present_host_cmd(soc_pkg::HOST_WRITE, soc_pkg::ram_addr_t'(a), d[7:0]);
        clear_host_cmd();
      end
      "H": read_host_byte(name, soc_pkg::ram_addr_t'(a), d[7:0]);
      "G": fill_scratch(a, d);
      "V": verify_scratch(name, a, d);
      "F": finish_host(name);
      "C": drive_cpu_write(a, d[7:0]);
      "Q": read_cpu_byte(name, a, d[7:0]);
      "K": begin
        @(negedge clk);
        check_flag(name, d[0], cpu_io_full);
      end
      "T": take_tx_byte(name, d[7:0]);
      default: begin
        other_errs++;
        $display("unknown opcode %c on trace line %0d", op, line_q[idx]);
      end
    endcase
  endtask

  initial begin : watchdog
    wait (trace_loaded === 1'b1);
    repeat (20 * op_q.size() + 100) @(posedge clk);
    $display("timeout: the trace did not complete in time");
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    int total;
    btnC         = 1'b1;
    tx_take      = 1'b0;
    cpu_req      = '0;
    host_cmd     = '0;
    seed         = 84;
    trace_loaded = 1'b0;
    byte_errs    = 0;
    flag_errs    = 0;
    tx_errs      = 0;
    other_errs   = 0;
    load_trace();
    repeat (3) @(posedge clk);
    btnC <= 1'b0;
    // reset chain holds two edges after release
    @(negedge clk);
    check_flag("reset cpu_rst hold 1", 1'b1, cpu_rst);
    @(negedge clk);
    check_flag("reset cpu_rst hold 2", 1'b1, cpu_rst);
    @(negedge clk);
    check_flag("reset cpu_rst release", 1'b0, cpu_rst);
    check_flag("reset cpu_rdy", 1'b1, cpu_rdy);
    check_flag("reset cpu_io_full", 1'b0, cpu_io_full);
    check_flag("reset tx valid", 1'b0, tx_out.valid);
    check_flag("reset host valid", 1'b0, host_rdata.valid);
    for (int i = 0; i < op_q.size(); i++) begin
      run_line(i);
    end
    repeat (2) @(posedge clk);
    total = byte_errs + flag_errs + tx_errs + other_errs;
    $display("errors: byte %0d, flag %0d, tx %0d, other %0d",
             byte_errs, flag_errs, tx_errs, other_errs);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- soc_trace.txt
# columns: opcode letter, hex address, hex data or expected value
# S start, W/H host write/read, G/V random fill/verify, C/Q cpu write/read, K full, T take, F finish
S 0 0
W 00010 a5
W 00011 3c
W 1fffe 7e
H 00010 a5
H 00011 3c
H 1fffe 7e
G 00100 8
V 00100 8
C 00010 ff
H 00010 a5
F 0 0
Q 00011 3c
Q 00010 a5
C 00200 5a
Q 00200 5a
C 30000 11
C 30000 22
C 30000 33
K 0 0
C 30000 44
K 0 1
C 30000 55
Q 30004 01
T 0 11
T 0 22
T 0 33
T 0 44
K 0 0
Q 30004 02

//--- compile.f
+incdir+.
soc_pkg.sv
sys_reset.sv
byte_ram.sv
host_link.sv
mem_bus_mux.sv
io_port.sv
soc_top.sv
tb_soc_top.sv

//--- Makefile
# verilator flow for the soc fabric testbench

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --top-module tb_soc_top -f compile.f
	out="$$(./obj_dir/Vtb_soc_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only -Wall --timing --top-module tb_soc_top -f compile.f

clean:
	rm -rf obj_dir
